// ==== rtl/mipsCpu_params.svh ====
`ifndef MIPS_CPU_PARAMS_SVH
`define MIPS_CPU_PARAMS_SVH

// Datapath and bus width
`define WORD_W 32

// General register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// $v0 is shown at the top level
`define V0_INDEX 2

// First fetch after reset, boot ROM region
`define RESET_VECTOR 32'hBFC0_0000

// Reaching this PC stops the core
`define HALT_ADDR 32'h0000_0000

// Shift amount field width
`define SHAMT_W 5

// Immediate field width in the I view
`define IMM_W 16

`endif

// ==== rtl/mipsPkg.sv ====
`include "mipsCpu_params.svh"

package mipsPkg;

    // Kept primary opcodes
    typedef enum logic [5:0] {
        OP_R     = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcodeT;

    // R-type function codes
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } functT;

    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC  = 2'd1,
        MEM   = 2'd2,
        HALT  = 2'd3
    } cpuStateT;

    typedef struct packed {
        opcodeT                 opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`SHAMT_W-1:0]    shamt;
        functT                  funct;
    } rViewT;

    typedef struct packed {
        opcodeT                 opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`IMM_W-1:0]      imm;
    } iViewT;

    typedef struct packed {
        opcodeT      opcode;
        logic [25:0] target; // Word index inside the 256 MB region
    } jViewT;

    // One fetched word, three decodings
    typedef union packed {
        rViewT r;
        iViewT i;
        jViewT j;
    } instrWordT;

endpackage

// ==== rtl/cpuControl.sv ====
`timescale 1ns/1ns
`include "mipsCpu_params.svh"

module cpuControl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 waitrequest,
    input  logic [`WORD_W-1:0]   readdata,
    input  logic [`WORD_W-1:0]   nextPc,
    input  logic [`WORD_W-1:0]   memAddr,
    input  logic                 isMemOp,
    input  logic [`WORD_W-1:0]   storeData,
    output mipsPkg::instrWordT   instr,
    output logic [`WORD_W-1:0]   pc,
    output logic                 execStrobe,
    output logic                 loadDone,
    output logic [`WORD_W-1:0]   loadData,
    output logic                 active,
    output logic [`WORD_W-1:0]   address,
    output logic                 read,
    output logic                 write,
    output logic [`WORD_W-1:0]   writedata,
    output logic [`WORD_W/8-1:0] byteenable
);
    import mipsPkg::*;

    cpuStateT state;
    logic     isStore;    // SW in the instruction register
    logic     accessDone; // Current bus access completes this cycle

    assign isStore    = isMemOp && (instr.i.opcode == OP_SW);
    assign accessDone = (read || write) && !waitrequest;

    // Control state, bus levels are registered
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc    <= `RESET_VECTOR;
            read  <= 1'b0; // Bus idle in the reset cycle
            write <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (!read) begin
                        // No fetch issued yet, only after reset or a jump to zero
                        if (pc == `HALT_ADDR) begin
                            state <= HALT;
                        end else begin
                            read <= 1'b1;
                        end
                    end else if (!waitrequest) begin
                        read  <= 1'b0; // Instruction latched below
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    pc <= nextPc;
                    if (isMemOp) begin
                        read  <= !isStore;
                        write <= isStore;
                        state <= MEM;
                    end else begin
                        read  <= (nextPc != `HALT_ADDR); // Next fetch starts now
                        state <= FETCH;
                    end
                end
                MEM: begin
                    if (accessDone) begin
                        read  <= (pc != `HALT_ADDR); // Straight into the next fetch
                        write <= 1'b0;
                        state <= FETCH;
                    end
                end
                default: begin
                    state <= HALT; // Stuck until reset
                end
            endcase
        end
    end

    // Address, store data and instruction register
    always_ff @(posedge clk) begin
        case (state)
            FETCH: begin
                if (!read) begin
                    address <= pc;
                end else if (!waitrequest) begin
                    instr <= readdata;
                end
            end
            EXEC: begin
                address   <= isMemOp ? memAddr : nextPc;
                writedata <= storeData; // rt operand, only seen by SW
            end
            MEM: begin
                if (accessDone) begin
                    address <= pc; // Already the next PC
                end
            end
            default: begin
                address <= address;
            end
        endcase
    end

    assign execStrobe = (state == EXEC);
    assign loadDone   = (state == MEM) && read && !waitrequest;
    assign loadData   = readdata;    // Zero read latency
    assign active     = (state != HALT);
    assign byteenable = '1;          // Word accesses only

    busExclusive: assert property (@(posedge clk) disable iff (reset)
        !(read && write));

    // Stalled access keeps its request unchanged
    busHold: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(writedata)
            && $stable(read) && $stable(write));

    haltQuiet: assert property (@(posedge clk) disable iff (reset)
        !active |=> !active && !read && !write);

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/1ns
`include "mipsCpu_params.svh"

module regFile (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`REG_ADDR_W-1:0]  rsIndex,
    input  logic [`REG_ADDR_W-1:0]  rtIndex,
    input  logic                    execStrobe,
    input  logic                    wrEnable,
    input  logic [`REG_ADDR_W-1:0]  wrIndex,
    input  logic [`WORD_W-1:0]      wrData,
    input  logic                    loadDone,
    input  logic [`REG_ADDR_W-1:0]  loadIndex,
    input  logic [`WORD_W-1:0]      loadData,
    output logic [`WORD_W-1:0]      rsData,
    output logic [`WORD_W-1:0]      rtData,
    output logic [`WORD_W-1:0]      registerV0
);
    logic [`WORD_W-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (execStrobe && wrEnable && (wrIndex != '0)) begin
            regs[wrIndex] <= wrData;     // ALU result
        end else if (loadDone && (loadIndex != '0)) begin
            regs[loadIndex] <= loadData; // LW data from the bus
        end
    end

    // Operand reads are combinational
    assign rsData     = regs[rsIndex];
    assign rtData     = regs[rtIndex];
    assign registerV0 = regs[`V0_INDEX];

    zeroReg: assert property (@(posedge clk) disable iff (reset)
        regs[0] == '0);

endmodule

// ==== rtl/aluExec.sv ====
`timescale 1ns/1ns
`include "mipsCpu_params.svh"

module aluExec (
    input  mipsPkg::instrWordT      instr,
    input  logic [`WORD_W-1:0]      pc,
    input  logic [`WORD_W-1:0]      rsData,
    input  logic [`WORD_W-1:0]      rtData,
    output logic [`WORD_W-1:0]      result,
    output logic                    wrEnable,
    output logic [`REG_ADDR_W-1:0]  wrIndex,
    output logic [`WORD_W-1:0]      nextPc,
    output logic [`WORD_W-1:0]      memAddr,
    output logic                    isMemOp
);
    import mipsPkg::*;

    logic [`WORD_W-1:0] pcPlus4;
    logic [`WORD_W-1:0] immSext;
    logic [`WORD_W-1:0] immZext;
    logic [`WORD_W-1:0] branchTarget;

    assign pcPlus4      = pc + 'd4;
    assign immSext      = {{(`WORD_W-`IMM_W){instr.i.imm[`IMM_W-1]}}, instr.i.imm};
    assign immZext      = {{(`WORD_W-`IMM_W){1'b0}}, instr.i.imm};
    assign branchTarget = pcPlus4 + {immSext[`WORD_W-3:0], 2'b00}; // Word offset
    assign memAddr      = rsData + immSext;
    assign isMemOp      = (instr.i.opcode == OP_LW) || (instr.i.opcode == OP_SW);

    always_comb begin
        result   = '0;
        wrEnable = 1'b0;
        wrIndex  = instr.i.rt; // I results land in rt
        nextPc   = pcPlus4;    // No delay slot
        case (instr.r.opcode)
            OP_R: begin
                wrIndex  = instr.r.rd;
                wrEnable = 1'b1;
                case (instr.r.funct)
                    FN_ADDU: result = rsData + rtData;
                    FN_SUBU: result = rsData - rtData;
                    FN_AND:  result = rsData & rtData;
                    FN_OR:   result = rsData | rtData;
                    FN_XOR:  result = rsData ^ rtData;
                    FN_SLT:  result = ($signed(rsData) < $signed(rtData)) ? 'd1 : 'd0;
                    FN_SLTU: result = (rsData < rtData) ? 'd1 : 'd0;
                    FN_SLL:  result = rtData << instr.r.shamt;
                    FN_SRL:  result = rtData >> instr.r.shamt;
                    FN_SRA:  result = $signed(rtData) >>> instr.r.shamt; // Keeps sign
                    FN_JR: begin
                        wrEnable = 1'b0;
                        nextPc   = rsData;
                    end
                    default: wrEnable = 1'b0; // Unsupported function, no effect
                endcase
            end
            OP_J:     nextPc = {pcPlus4[`WORD_W-1:28], instr.j.target, 2'b00};
            OP_BEQ: begin
                if (rsData == rtData) begin
                    nextPc = branchTarget;
                end
            end
            OP_BNE: begin
                if (rsData != rtData) begin
                    nextPc = branchTarget;
                end
            end
            OP_ADDIU: begin
                result   = rsData + immSext;
                wrEnable = 1'b1;
            end
            OP_SLTI: begin
                result   = ($signed(rsData) < $signed(immSext)) ? 'd1 : 'd0;
                wrEnable = 1'b1;
            end
            OP_SLTIU: begin
                result   = (rsData < immSext) ? 'd1 : 'd0; // Sign-extended, compared unsigned
                wrEnable = 1'b1;
            end
            OP_ANDI: begin
                result   = rsData & immZext;
                wrEnable = 1'b1;
            end
            OP_ORI: begin
                result   = rsData | immZext;
                wrEnable = 1'b1;
            end
            OP_XORI: begin
                result   = rsData ^ immZext;
                wrEnable = 1'b1;
            end
            OP_LUI: begin
                result   = {instr.i.imm, {(`WORD_W-`IMM_W){1'b0}}};
                wrEnable = 1'b1;
            end
            default: ; // LW writes later through the load path, SW never
        endcase
    end

    // Control flow and stores must leave the registers alone
    noStrayWrite: assert final (!(wrEnable && ((instr.r.opcode inside {OP_SW, OP_J, OP_BEQ,
        OP_BNE}) || (instr.r.opcode == OP_R && instr.r.funct == FN_JR))));

endmodule

// ==== rtl/mipsCpuBus.sv ====
`timescale 1ns/1ns
`include "mipsCpu_params.svh"

module mipsCpuBus (
    input  logic                 clk,
    input  logic                 reset,
    output logic                 active,
    output logic [`WORD_W-1:0]   registerV0,
    output logic [`WORD_W-1:0]   address,
    output logic                 write,
    output logic                 read,
    input  logic                 waitrequest,
    output logic [`WORD_W-1:0]   writedata,
    output logic [`WORD_W/8-1:0] byteenable,
    input  logic [`WORD_W-1:0]   readdata
);
    import mipsPkg::*;

    instrWordT              instr;
    logic [`WORD_W-1:0]     pc;
    logic [`WORD_W-1:0]     rsData;
    logic [`WORD_W-1:0]     rtData;
    logic [`WORD_W-1:0]     result;
    logic                   wrEnable;
    logic [`REG_ADDR_W-1:0] wrIndex;
    logic [`WORD_W-1:0]     nextPc;
    logic [`WORD_W-1:0]     memAddr;
    logic                   isMemOp;
    logic                   execStrobe;
    logic                   loadDone;
    logic [`WORD_W-1:0]     loadData;

    // Fetch, sequencing and bus master
    cpuControl control (
        .clk        (clk),
        .reset      (reset),
        .waitrequest(waitrequest),
        .readdata   (readdata),
        .nextPc     (nextPc),
        .memAddr    (memAddr),
        .isMemOp    (isMemOp),
        .storeData  (rtData),
        .instr      (instr),
        .pc         (pc),
        .execStrobe (execStrobe),
        .loadDone   (loadDone),
        .loadData   (loadData),
        .active     (active),
        .address    (address),
        .read       (read),
        .write      (write),
        .writedata  (writedata),
        .byteenable (byteenable)
    );

    regFile regs (
        .clk       (clk),
        .reset     (reset),
        .rsIndex   (instr.r.rs),
        .rtIndex   (instr.r.rt),
        .execStrobe(execStrobe),
        .wrEnable  (wrEnable),
        .wrIndex   (wrIndex),
        .wrData    (result),
        .loadDone  (loadDone),
        .loadIndex (instr.i.rt), // LW target
        .loadData  (loadData),
        .rsData    (rsData),
        .rtData    (rtData),
        .registerV0(registerV0)
    );

    aluExec alu (
        .instr   (instr),
        .pc      (pc),
        .rsData  (rsData),
        .rtData  (rtData),
        .result  (result),
        .wrEnable(wrEnable),
        .wrIndex (wrIndex),
        .nextPc  (nextPc),
        .memAddr (memAddr),
        .isMemOp (isMemOp)
    );

endmodule

// ==== verif/mipsCpuBusTb.sv ====
`timescale 1ns/1ns
`include "mipsCpu_params.svh"

module mipsCpuBusTb;
    import mipsPkg::*;

    localparam int PROGRAMS    = 4;
    localparam int MAX_INSTR   = 200;   // Executed instructions per program, upper bound
    localparam int MAX_STALL   = 3;
    localparam int ROM_WORDS   = 128;
    localparam int RAM_WORDS   = 64;
    localparam logic [31:0] RAM_BASE = 32'h0000_1000;
    localparam longint WATCHDOG_NS = longint'(PROGRAMS) * MAX_INSTR * (MAX_STALL + 3) * 40;

    logic               clk;
    logic               reset;
    logic               waitrequest;
    logic [`WORD_W-1:0] readdata;
    logic               active;
    logic [`WORD_W-1:0] registerV0;
    logic [`WORD_W-1:0] address;
    logic               write;
    logic               read;
    logic [`WORD_W-1:0] writedata;
    logic [3:0]         byteenable;

    logic [`WORD_W-1:0] rom     [ROM_WORDS];
    logic [`WORD_W-1:0] ram     [RAM_WORDS];
    logic [`WORD_W-1:0] refRam  [RAM_WORDS];
    logic [`WORD_W-1:0] refRegs [`REG_COUNT];
    instrWordT          prog [$];
    logic [31:0]        rngState = 32'h3d5e_a647;
    int                 stallLeft = 0;
    int                 valueErrors = 0;
    int                 protocolErrors = 0;

    mipsCpuBus uut (
        .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic logic [31:0] memRead(logic [31:0] addr);
        if (addr >= `RESET_VECTOR && addr < `RESET_VECTOR + ROM_WORDS * 4)
            return rom[(addr - `RESET_VECTOR) >> 2];
        else if (addr >= RAM_BASE && addr < RAM_BASE + RAM_WORDS * 4)
            return ram[(addr - RAM_BASE) >> 2];
        return 32'hDEAD_BEEF; // Unmapped
    endfunction

    // Avalon slave, every access waits at least one cycle plus a random stall
    always @(posedge clk) begin
        if (reset) begin
            waitrequest <= 1'b1;
        end else if (read || write) begin
            if (!waitrequest) begin
                if (write) begin
                    if (byteenable != 4'hF) begin
                        $display("Write to %h without all byte enables set", address);
                        protocolErrors++;
                    end
                    if (address >= RAM_BASE && address < RAM_BASE + RAM_WORDS * 4)
                        ram[(address - RAM_BASE) >> 2] = writedata;
                    else begin
                        $display("Write to unmapped address %h", address);
                        protocolErrors++;
                    end
                end
                waitrequest <= 1'b1;
                stallLeft   <= xorshift() % (MAX_STALL + 1);
            end else if (stallLeft == 0) begin
                waitrequest <= 1'b0;
                readdata    <= memRead(address);
            end else begin
                stallLeft <= stallLeft - 1;
            end
        end
    end

    // Instruction encoders
    function automatic instrWordT encR(functT fn, int rs, int rt, int rd, int shamt);
        instrWordT w;
        w.r.opcode = OP_R;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.shamt  = shamt;
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic instrWordT encI(opcodeT op, int rs, int rt, logic [15:0] imm);
        instrWordT w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic instrWordT encJ(logic [31:0] dest);
        instrWordT w;
        w.j.opcode = OP_J;
        w.j.target = dest[27:2];
        return w;
    endfunction

    task automatic emit(instrWordT w);
        prog.push_back(w);
    endtask

    task automatic loadConst(int rd, logic [31:0] value);
        emit(encI(OP_LUI, 0, rd, value[31:16]));
        emit(encI(OP_ORI, rd, rd, value[15:0]));
    endtask

    // $v0 = ($v0 << 3) ^ reg, over a range of registers
    task automatic foldIntoV0(int first, int last);
        for (int r = first; r <= last; r++) begin
            emit(encR(FN_SLL, 0, 2, 2, 3));
            emit(encR(FN_XOR, 2, r, 2, 0));
        end
    endtask

    function automatic void setRefReg(logic [4:0] idx, logic [31:0] value);
        if (idx != 0)
            refRegs[idx] = value;
    endfunction

    // Instruction-set model, runs the loaded program on refRegs and refRam
    function automatic logic [31:0] refRun();
        instrWordT   w;
        logic [31:0] pc;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] sImm;
        logic [31:0] zImm;
        logic [31:0] npc;
        logic [31:0] ea;
        int          steps;
        foreach (refRegs[k]) refRegs[k] = '0;
        pc    = `RESET_VECTOR;
        steps = 0;
        while (pc != `HALT_ADDR && steps < MAX_INSTR) begin
            w    = rom[(pc - `RESET_VECTOR) >> 2];
            rs   = refRegs[w.i.rs];
            rt   = refRegs[w.i.rt];
            sImm = {{16{w.i.imm[15]}}, w.i.imm};
            zImm = {16'h0, w.i.imm};
            npc  = pc + 4;
            ea   = rs + sImm;
            case (w.r.opcode)
                OP_R: case (w.r.funct)
                    FN_ADDU: setRefReg(w.r.rd, rs + rt);
                    FN_SUBU: setRefReg(w.r.rd, rs - rt);
                    FN_AND:  setRefReg(w.r.rd, rs & rt);
                    FN_OR:   setRefReg(w.r.rd, rs | rt);
                    FN_XOR:  setRefReg(w.r.rd, rs ^ rt);
                    FN_SLT:  setRefReg(w.r.rd, {31'h0, $signed(rs) < $signed(rt)});
                    FN_SLTU: setRefReg(w.r.rd, {31'h0, rs < rt});
                    FN_SLL:  setRefReg(w.r.rd, rt << w.r.shamt);
                    FN_SRL:  setRefReg(w.r.rd, rt >> w.r.shamt);
                    FN_SRA:  setRefReg(w.r.rd, $unsigned($signed(rt) >>> w.r.shamt));
                    FN_JR:   npc = rs;
                    default: ;
                endcase
                OP_J:     npc = {npc[31:28], w.j.target, 2'b00};
                OP_BEQ:   if (rs == rt) npc = npc + (sImm << 2);
                OP_BNE:   if (rs != rt) npc = npc + (sImm << 2);
                OP_ADDIU: setRefReg(w.i.rt, rs + sImm);
                OP_SLTI:  setRefReg(w.i.rt, {31'h0, $signed(rs) < $signed(sImm)});
                OP_SLTIU: setRefReg(w.i.rt, {31'h0, rs < sImm});
                OP_ANDI:  setRefReg(w.i.rt, rs & zImm);
                OP_ORI:   setRefReg(w.i.rt, rs | zImm);
                OP_XORI:  setRefReg(w.i.rt, rs ^ zImm);
                OP_LUI:   setRefReg(w.i.rt, {w.i.imm, 16'h0});
                OP_LW:    setRefReg(w.i.rt, refRam[(ea - RAM_BASE) >> 2]);
                OP_SW:    refRam[(ea - RAM_BASE) >> 2] = rt;
                default: ;
            endcase
            pc = npc;
            steps++;
        end
        return refRegs[`V0_INDEX];
    endfunction

    task automatic checkV0(string name, logic [`WORD_W-1:0] expected, logic [`WORD_W-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: $v0 expected %h actual %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkMem(string name, logic [`WORD_W-1:0] addr,
                            logic [`WORD_W-1:0] expected, logic [`WORD_W-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: mem[%h] expected %h actual %h", name, addr, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkAddr(string name, logic [`WORD_W-1:0] expected, logic [`WORD_W-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: first fetch expected %h actual %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    // Core must stay quiet once halted
    task automatic checkHalt(string name);
        repeat (12) begin
            @(negedge clk);
            if (read !== 1'b0 || write !== 1'b0 || active !== 1'b0) begin
                $display("%s: bus activity or active high after halt", name);
                protocolErrors++;
            end
        end
    endtask

    task automatic runProgram(string name);
        logic [31:0] expectedV0;
        foreach (rom[k]) rom[k] = (k < prog.size()) ? prog[k] : '0;
        foreach (ram[k]) begin
            ram[k]    = {RAM_BASE[15:0] + 16'(k * 4), ~(RAM_BASE[15:0] + 16'(k * 4))} ^ 32'h5A5A_C3C3;
            refRam[k] = ram[k];
        end
        expectedV0 = refRun();
        @(posedge clk);
        reset <= 1'b1;
        for (int c = 0; c < 5; c++) begin
            @(negedge clk);
            if (c > 0 && (read !== 1'b0 || write !== 1'b0 || active !== 1'b1)) begin
                $display("%s: bus not idle or core inactive during reset", name);
                protocolErrors++;
            end
            @(posedge clk);
        end
        reset <= 1'b0;
        @(negedge clk);
        if (read !== 1'b0 || write !== 1'b0 || active !== 1'b1) begin
            $display("%s: bus not idle in the first cycle after reset", name);
            protocolErrors++;
        end
        while (!read) @(negedge clk);
        checkAddr(name, `RESET_VECTOR, address);
        while (active) @(negedge clk);
        checkV0(name, expectedV0, registerV0);
        foreach (ram[k]) checkMem(name, RAM_BASE + k * 4, refRam[k], ram[k]);
        checkHalt(name);
        prog.delete();
    endtask

    // Stimulus and checking sequence
    initial begin
        int jAt;
        reset       = 1'b1;
        waitrequest = 1'b1;
        readdata    = '0;

        // R-type on random operands
        for (int r = 8; r <= 11; r++) loadConst(r, xorshift());
        loadConst(12, 32'h8000_0001);
        emit(encR(FN_ADDU, 8, 9, 13, 0));
        emit(encR(FN_SUBU, 10, 11, 14, 0));
        emit(encR(FN_AND, 8, 10, 15, 0));
        emit(encR(FN_OR, 9, 11, 16, 0));
        emit(encR(FN_XOR, 13, 14, 17, 0));
        emit(encR(FN_SLT, 9, 12, 18, 0));
        emit(encR(FN_SLTU, 9, 12, 19, 0));
        emit(encR(FN_SLT, 12, 8, 20, 0));
        emit(encR(FN_SLL, 0, 8, 21, 7));
        emit(encR(FN_SRL, 0, 12, 22, 4));
        emit(encR(FN_SRA, 0, 12, 23, 5));
        foldIntoV0(13, 23);
        emit(encR(FN_JR, 0, 0, 0, 0));
        runProgram("rtype");

        // I-type, extension rules and LUI
        loadConst(8, xorshift());
        emit(encI(OP_ADDIU, 8, 9, 16'hFFF0));
        emit(encI(OP_ADDIU, 0, 10, 16'h8001));
        emit(encI(OP_SLTI, 8, 11, 16'hFF00));
        emit(encI(OP_SLTIU, 8, 12, 16'hFF00));
        emit(encI(OP_SLTI, 10, 13, 16'h0005));
        emit(encI(OP_ANDI, 8, 14, 16'h8F0F));
        emit(encI(OP_ORI, 9, 15, 16'h8000));
        emit(encI(OP_XORI, 8, 16, 16'hFFFF));
        emit(encI(OP_LUI, 0, 17, 16'h8765));
        foldIntoV0(9, 17);
        emit(encR(FN_JR, 0, 0, 0, 0));
        runProgram("itype");

        // Stores and loads under random stalls
        emit(encI(OP_ORI, 0, 4, 16'h1010));
        loadConst(8, xorshift());
        loadConst(9, xorshift());
        emit(encI(OP_SW, 4, 8, 16'h0000));
        emit(encI(OP_SW, 4, 9, 16'h0008));
        emit(encI(OP_LW, 4, 11, 16'h0008));
        emit(encI(OP_LW, 4, 2, 16'h0000));
        emit(encR(FN_ADDU, 2, 11, 2, 0));
        emit(encI(OP_SW, 4, 2, 16'h000C));
        emit(encI(OP_LW, 4, 12, 16'hFFFC));  // Untouched fill word
        emit(encR(FN_XOR, 2, 12, 2, 0));
        emit(encR(FN_JR, 0, 0, 0, 0));
        runProgram("memory");

        // Branches and jumps, skipped ORIs leave holes in $v0
        emit(encI(OP_ORI, 0, 2, 16'h0001));
        emit(encI(OP_ORI, 0, 8, 16'h0005));
        emit(encI(OP_ORI, 0, 9, 16'h0005));
        emit(encI(OP_BEQ, 8, 9, 16'h0001));  // Taken
        emit(encI(OP_ORI, 2, 2, 16'h0010));
        emit(encI(OP_BNE, 8, 9, 16'h0001));  // Not taken
        emit(encI(OP_ORI, 2, 2, 16'h0020));
        emit(encI(OP_BEQ, 8, 0, 16'h0001));  // Not taken
        emit(encI(OP_ORI, 2, 2, 16'h0040));
        emit(encI(OP_BNE, 8, 0, 16'h0002));  // Taken, skips two
        emit(encI(OP_ORI, 2, 2, 16'h0080));
        emit(encI(OP_ORI, 2, 2, 16'h0100));
        jAt = prog.size();
        emit(encJ(`RESET_VECTOR + (jAt + 2) * 4));
        emit(encI(OP_ORI, 2, 2, 16'h0200));
        emit(encI(OP_ORI, 2, 2, 16'h0400));
        emit(encI(OP_ORI, 0, 10, 16'h0003));
        emit(encI(OP_ADDIU, 2, 2, 16'h1000)); // Loop body, three passes
        emit(encI(OP_ADDIU, 10, 10, 16'hFFFF));
        emit(encI(OP_BNE, 10, 0, 16'hFFFD));
        emit(encR(FN_JR, 0, 0, 0, 0));
        runProgram("branch");

        $display("Run complete: %0d value errors, %0d protocol errors",
                 valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all programs finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/mipsPkg.sv
rtl/cpuControl.sv
rtl/regFile.sv
rtl/aluExec.sv
rtl/mipsCpuBus.sv
verif/mipsCpuBusTb.sv

// ==== Bender.yml ====
package:
  name: mipsCpuBus

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mipsPkg.sv
      - rtl/cpuControl.sv
      - rtl/regFile.sv
      - rtl/aluExec.sv
      - rtl/mipsCpuBus.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/mipsCpuBusTb.sv
